//--- compile.f
source/exu_pkg.sv
source/exu_regfile.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_issue.sv
source/exu_execute.sv
source/exu_writeback.sv
source/exu_top.sv
tests/tb_exu.sv

//--- run.sh
#!/bin/sh
# build the execute unit testbench with Verilator and run it
verilator --binary --timing --timescale 1ns/10ps -f compile.f --top-module tb_exu -o tb_exu &&
   ./obj_dir/tb_exu | tee /dev/stderr | grep -qF '** PASS **' ||
   { echo "simulation did not pass"; exit 1; }

//--- source/exu_alu.sv
`timescale 1ns/10ps

module exu_alu (
   input  logic [exu_pkg::XLEN-1:0]     a,
   input  logic [exu_pkg::XLEN-1:0]     b,
   input  logic [exu_pkg::ALU_OP_W-1:0] op,
   output logic [exu_pkg::XLEN-1:0]     result
);

   import exu_pkg::*;

   logic [SHAMT_W-1:0] shamt;

   assign shamt = b[SHAMT_W-1:0];

   always_comb begin
      case (op)
         ALU_ADD:   result = a + b;
         ALU_SUB:   result = a - b;
         ALU_AND:   result = a & b;
         ALU_OR:    result = a | b;
         ALU_XOR:   result = a ^ b;
         ALU_SLL:   result = a << shamt;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
         // compares give 0 or 1
         ALU_SLT:   result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         ALU_SLTU:  result = {{(XLEN-1){1'b0}}, a < b};
         ALU_PASSB: result = b;
         default:   result = '0;
      endcase
   end

endmodule

//--- source/exu_branch.sv
`timescale 1ns/10ps

module exu_branch (
   input  logic [exu_pkg::BRU_OP_W-1:0] op,
   input  logic [exu_pkg::XLEN-1:0]     rs1_data,
   input  logic [exu_pkg::XLEN-1:0]     rs2_data,
   input  logic [exu_pkg::XLEN-1:0]     pc,
   input  logic [exu_pkg::XLEN-1:0]     offset,
   output logic                         taken,
   output logic [exu_pkg::XLEN-1:0]     target,
   output logic [exu_pkg::XLEN-1:0]     link
);

   import exu_pkg::*;

   always_comb begin
      case (op)
         BRU_BEQ:  taken = rs1_data == rs2_data;
         BRU_BNE:  taken = rs1_data != rs2_data;
         BRU_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
         BRU_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
         BRU_BLTU: taken = rs1_data < rs2_data;
         BRU_BGEU: taken = rs1_data >= rs2_data;
         BRU_B:    taken = 1'b1;
         BRU_JIRL: taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // only the register jump is based on rs1
   assign target = (op == BRU_JIRL) ? rs1_data + offset : pc + offset;
   assign link   = pc + XLEN'(INSTR_BYTES);

endmodule

//--- source/exu_execute.sv
`timescale 1ns/10ps

module exu_execute (
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             e_vld,
   input  logic                             e_alu_vld,
   input  logic                             e_bru_vld,
   input  logic                             e_wen,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   e_rd,
   input  logic [exu_pkg::XLEN-1:0]         e_pc,
   input  logic [exu_pkg::XLEN-1:0]         e_imm,
   input  logic [exu_pkg::ALU_OP_W-1:0]     e_alu_op,
   input  logic                             e_alu_a_pc,
   input  logic                             e_alu_b_imm,
   input  logic [exu_pkg::BRU_OP_W-1:0]     e_bru_op,
   input  logic [exu_pkg::XLEN-1:0]         e_bru_offset,
   input  logic [exu_pkg::XLEN-1:0]         e_rs1_data,
   input  logic [exu_pkg::XLEN-1:0]         e_rs2_data,

   output logic                             e_taken,
   output logic                             m_wen,
   output logic [exu_pkg::REG_ADDR_W-1:0]   m_rd,
   output logic [exu_pkg::XLEN-1:0]         m_result,
   output logic                             m_taken,
   output logic [exu_pkg::XLEN-1:0]         m_target
);

   import exu_pkg::*;

   logic [XLEN-1:0] alu_a;
   logic [XLEN-1:0] alu_b;
   logic [XLEN-1:0] alu_res;
   logic            bru_taken;
   logic [XLEN-1:0] bru_target;
   logic [XLEN-1:0] bru_link;
   logic [XLEN-1:0] result;

   assign alu_a = e_alu_a_pc  ? e_pc  : e_rs1_data;
   assign alu_b = e_alu_b_imm ? e_imm : e_rs2_data;

   exu_alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (e_alu_op),
      .result (alu_res)
   );

   exu_branch u_bru (
      .op       (e_bru_op),
      .rs1_data (e_rs1_data),
      .rs2_data (e_rs2_data),
      .pc       (e_pc),
      .offset   (e_bru_offset),
      .taken    (bru_taken),
      .target   (bru_target),
      .link     (bru_link)
   );

   assign e_taken = e_vld & e_bru_vld & bru_taken;

   // alu result or link address, one-hot by unit
   assign result = ({XLEN{e_alu_vld}} & alu_res) |
                   ({XLEN{e_bru_vld}} & bru_link);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_wen    <= 1'b0;
         m_rd     <= '0;
         m_result <= '0;
         m_taken  <= 1'b0;
         m_target <= '0;
      end else begin
         m_wen    <= e_vld & e_wen;
         m_rd     <= e_rd;
         m_result <= result;
         m_taken  <= e_taken;
         m_target <= bru_target;
      end
   end

endmodule

//--- source/exu_issue.sv
`timescale 1ns/10ps

module exu_issue (
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             vld,
   input  logic [exu_pkg::XLEN-1:0]         pc,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs2,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rd,
   input  logic                             wen,
   input  logic [exu_pkg::XLEN-1:0]         imm,
   input  logic                             alu_vld,
   input  logic [exu_pkg::ALU_OP_W-1:0]     alu_op,
   input  logic                             alu_a_pc,
   input  logic                             alu_b_imm,
   input  logic                             bru_vld,
   input  logic [exu_pkg::BRU_OP_W-1:0]     bru_op,
   input  logic [exu_pkg::XLEN-1:0]         bru_offset,

   input  logic                             e_taken,
   input  logic                             m_taken,
   input  logic                             m_wen,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   m_rd,
   input  logic [exu_pkg::XLEN-1:0]         m_result,
   input  logic                             w_wen,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   w_rd,
   input  logic [exu_pkg::XLEN-1:0]         w_data,
   input  logic                             w_taken,

   output logic                             e_vld,
   output logic                             e_alu_vld,
   output logic                             e_bru_vld,
   output logic                             e_wen,
   output logic [exu_pkg::REG_ADDR_W-1:0]   e_rd,
   output logic [exu_pkg::XLEN-1:0]         e_pc,
   output logic [exu_pkg::XLEN-1:0]         e_imm,
   output logic [exu_pkg::ALU_OP_W-1:0]     e_alu_op,
   output logic                             e_alu_a_pc,
   output logic                             e_alu_b_imm,
   output logic [exu_pkg::BRU_OP_W-1:0]     e_bru_op,
   output logic [exu_pkg::XLEN-1:0]         e_bru_offset,
   output logic [exu_pkg::XLEN-1:0]         e_rs1_data,
   output logic [exu_pkg::XLEN-1:0]         e_rs2_data
);

   import exu_pkg::*;

   logic                  flush;
   logic                  accept;
   logic [XLEN-1:0]       rs1_data_d;
   logic [XLEN-1:0]       rs2_data_d;
   logic [REG_ADDR_W-1:0] rs1_e;
   logic [REG_ADDR_W-1:0] rs2_e;
   logic [XLEN-1:0]       rs1_data_e;
   logic [XLEN-1:0]       rs2_data_e;

   // a taken branch anywhere in E, M or W kills the D slot
   assign flush  = e_taken | m_taken | w_taken;
   assign accept = vld & ~flush;

   exu_regfile u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr0 (rs1),
      .raddr1 (rs2),
      .waddr  (w_rd),
      .wen    (w_wen),
      .wdata  (w_data),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d)
   );

   // younger producer in M wins over W
   function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] src,
                                               input logic [XLEN-1:0]       rf_data);
      if (src == '0) begin
         return rf_data;
      end else if (m_wen && m_rd == src) begin
         return m_result;
      end else if (w_wen && w_rd == src) begin
         return w_data;
      end
      return rf_data;
   endfunction

   always_comb begin
      e_rs1_data = forward(rs1_e, rs1_data_e);
      e_rs2_data = forward(rs2_e, rs2_data_e);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         e_vld     <= 1'b0;
         e_alu_vld <= 1'b0;
         e_bru_vld <= 1'b0;
         e_wen     <= 1'b0;
      end else begin
         e_vld <= accept;
         if (accept) begin
            e_alu_vld <= alu_vld;
            e_bru_vld <= bru_vld;
            e_wen     <= wen;
         end
      end
   end

   // instruction payload, held while the slot is empty
   always_ff @(posedge clk) begin
      if (accept) begin
         e_rd         <= rd;
         e_pc         <= pc;
         e_imm        <= imm;
         e_alu_op     <= alu_op;
         e_alu_a_pc   <= alu_a_pc;
         e_alu_b_imm  <= alu_b_imm;
         e_bru_op     <= bru_op;
         e_bru_offset <= bru_offset;
         rs1_e        <= rs1;
         rs2_e        <= rs2;
         rs1_data_e   <= rs1_data_d;
         rs2_data_e   <= rs2_data_d;
      end
   end

endmodule

//--- source/exu_pkg.sv
package exu_pkg;

   // datapath and register file sizes
   localparam int XLEN        = 32;
   localparam int REG_ADDR_W  = 5;
   localparam int NUM_REGS    = 32;
   localparam int SHAMT_W     = 5;

   // pc step from a branch to its link address
   localparam int INSTR_BYTES = 4;

   // alu operations
   localparam int ALU_OP_W = 4;
   localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'h0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'h1;
   localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'h2;
   localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'h3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'h4;
   localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'h5;
   localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'h6;
   localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'h7;
   localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'h8;
   localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'h9;
   localparam logic [ALU_OP_W-1:0] ALU_PASSB = 4'ha;

   // branch unit operations
   localparam int BRU_OP_W = 4;
   localparam logic [BRU_OP_W-1:0] BRU_BEQ  = 4'h0;
   localparam logic [BRU_OP_W-1:0] BRU_BNE  = 4'h1;
   localparam logic [BRU_OP_W-1:0] BRU_BLT  = 4'h2;
   localparam logic [BRU_OP_W-1:0] BRU_BGE  = 4'h3;
   localparam logic [BRU_OP_W-1:0] BRU_BLTU = 4'h4;
   localparam logic [BRU_OP_W-1:0] BRU_BGEU = 4'h5;
   localparam logic [BRU_OP_W-1:0] BRU_B    = 4'h6;
   localparam logic [BRU_OP_W-1:0] BRU_JIRL = 4'h7;

endpackage

//--- source/exu_regfile.sv
`timescale 1ns/10ps

module exu_regfile (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   raddr0,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   raddr1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   waddr,
   input  logic                             wen,
   input  logic [exu_pkg::XLEN-1:0]         wdata,
   output logic [exu_pkg::XLEN-1:0]         rdata0,
   output logic [exu_pkg::XLEN-1:0]         rdata1
);

   import exu_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   // r0 reads zero, a same-cycle write is seen by the reader
   function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (wen && waddr == addr) begin
         return wdata;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rdata0 = read_port(raddr0);
      rdata1 = read_port(raddr1);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

endmodule

//--- source/exu_top.sv
`timescale 1ns/10ps

module exu_top (
   input  logic                             clk,
   input  logic                             rst_n,

   // decoded instruction in D
   input  logic                             vld,
   input  logic [exu_pkg::XLEN-1:0]         pc,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs1,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rs2,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   rd,
   input  logic                             wen,
   input  logic [exu_pkg::XLEN-1:0]         imm,

   input  logic                             alu_vld,
   input  logic [exu_pkg::ALU_OP_W-1:0]     alu_op,
   input  logic                             alu_a_pc,
   input  logic                             alu_b_imm,

   input  logic                             bru_vld,
   input  logic [exu_pkg::BRU_OP_W-1:0]     bru_op,
   input  logic [exu_pkg::XLEN-1:0]         bru_offset,

   // redirect to fetch
   output logic                             branch,
   output logic [exu_pkg::XLEN-1:0]         brn_addr,

   // commit port
   output logic                             wb_vld,
   output logic [exu_pkg::REG_ADDR_W-1:0]   wb_rd,
   output logic [exu_pkg::XLEN-1:0]         wb_data
);

   import exu_pkg::*;

   // E stage
   logic                  e_vld;
   logic                  e_alu_vld;
   logic                  e_bru_vld;
   logic                  e_wen;
   logic [REG_ADDR_W-1:0] e_rd;
   logic [XLEN-1:0]       e_pc;
   logic [XLEN-1:0]       e_imm;
   logic [ALU_OP_W-1:0]   e_alu_op;
   logic                  e_alu_a_pc;
   logic                  e_alu_b_imm;
   logic [BRU_OP_W-1:0]   e_bru_op;
   logic [XLEN-1:0]       e_bru_offset;
   logic [XLEN-1:0]       e_rs1_data;
   logic [XLEN-1:0]       e_rs2_data;
   logic                  e_taken;

   // M stage
   logic                  m_wen;
   logic [REG_ADDR_W-1:0] m_rd;
   logic [XLEN-1:0]       m_result;
   logic                  m_taken;
   logic [XLEN-1:0]       m_target;

   // W stage
   logic                  w_wen;
   logic [REG_ADDR_W-1:0] w_rd;
   logic [XLEN-1:0]       w_data;
   logic                  w_taken;

   exu_issue u_issue (
      .clk          (clk),
      .rst_n        (rst_n),
      .vld          (vld),
      .pc           (pc),
      .rs1          (rs1),
      .rs2          (rs2),
      .rd           (rd),
      .wen          (wen),
      .imm          (imm),
      .alu_vld      (alu_vld),
      .alu_op       (alu_op),
      .alu_a_pc     (alu_a_pc),
      .alu_b_imm    (alu_b_imm),
      .bru_vld      (bru_vld),
      .bru_op       (bru_op),
      .bru_offset   (bru_offset),
      .e_taken      (e_taken),
      .m_taken      (m_taken),
      .m_wen        (m_wen),
      .m_rd         (m_rd),
      .m_result     (m_result),
      .w_wen        (w_wen),
      .w_rd         (w_rd),
      .w_data       (w_data),
      .w_taken      (w_taken),
      .e_vld        (e_vld),
      .e_alu_vld    (e_alu_vld),
      .e_bru_vld    (e_bru_vld),
      .e_wen        (e_wen),
      .e_rd         (e_rd),
      .e_pc         (e_pc),
      .e_imm        (e_imm),
      .e_alu_op     (e_alu_op),
      .e_alu_a_pc   (e_alu_a_pc),
      .e_alu_b_imm  (e_alu_b_imm),
      .e_bru_op     (e_bru_op),
      .e_bru_offset (e_bru_offset),
      .e_rs1_data   (e_rs1_data),
      .e_rs2_data   (e_rs2_data)
   );

   exu_execute u_execute (
      .clk          (clk),
      .rst_n        (rst_n),
      .e_vld        (e_vld),
      .e_alu_vld    (e_alu_vld),
      .e_bru_vld    (e_bru_vld),
      .e_wen        (e_wen),
      .e_rd         (e_rd),
      .e_pc         (e_pc),
      .e_imm        (e_imm),
      .e_alu_op     (e_alu_op),
      .e_alu_a_pc   (e_alu_a_pc),
      .e_alu_b_imm  (e_alu_b_imm),
      .e_bru_op     (e_bru_op),
      .e_bru_offset (e_bru_offset),
      .e_rs1_data   (e_rs1_data),
      .e_rs2_data   (e_rs2_data),
      .e_taken      (e_taken),
      .m_wen        (m_wen),
      .m_rd         (m_rd),
      .m_result     (m_result),
      .m_taken      (m_taken),
      .m_target     (m_target)
   );

   exu_writeback u_writeback (
      .clk          (clk),
      .rst_n        (rst_n),
      .m_wen        (m_wen),
      .m_rd         (m_rd),
      .m_result     (m_result),
      .m_taken      (m_taken),
      .m_target     (m_target),
      .w_wen        (w_wen),
      .w_rd         (w_rd),
      .w_data       (w_data),
      .w_taken      (w_taken),
      .branch       (branch),
      .brn_addr     (brn_addr),
      .wb_vld       (wb_vld),
      .wb_rd        (wb_rd),
      .wb_data      (wb_data)
   );

endmodule

//--- source/exu_writeback.sv
`timescale 1ns/10ps

module exu_writeback (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             m_wen,
   input  logic [exu_pkg::REG_ADDR_W-1:0]   m_rd,
   input  logic [exu_pkg::XLEN-1:0]         m_result,
   input  logic                             m_taken,
   input  logic [exu_pkg::XLEN-1:0]         m_target,

   output logic                             w_wen,
   output logic [exu_pkg::REG_ADDR_W-1:0]   w_rd,
   output logic [exu_pkg::XLEN-1:0]         w_data,
   output logic                             w_taken,
   output logic                             branch,
   output logic [exu_pkg::XLEN-1:0]         brn_addr,
   output logic                             wb_vld,
   output logic [exu_pkg::REG_ADDR_W-1:0]   wb_rd,
   output logic [exu_pkg::XLEN-1:0]         wb_data
);

   import exu_pkg::*;

   logic [XLEN-1:0] w_target;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         w_wen   <= 1'b0;
         w_taken <= 1'b0;
      end else begin
         w_wen   <= m_wen;
         w_taken <= m_taken;
      end
   end

   always_ff @(posedge clk) begin
      w_rd     <= m_rd;
      w_data   <= m_result;
      w_target <= m_target;
   end

   // every register write is a commit, r0 included
   assign wb_vld   = w_wen;
   assign wb_rd    = w_rd;
   assign wb_data  = w_data;

   assign branch   = w_taken;
   assign brn_addr = w_target;

endmodule

//--- tests/tb_exu.sv
`timescale 1ns/10ps

module tb_exu;

   import exu_pkg::*;

   localparam logic [ALU_OP_W-1:0] alu_ops [11] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
      ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB};
   localparam logic [BRU_OP_W-1:0] cond_ops [6] = '{BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE,
      BRU_BLTU, BRU_BGEU};

   // equal, negative against positive, and reversed branch sources
   localparam logic [REG_ADDR_W-1:0] pair_a [3] = '{5'd7, 5'd9, 5'd10};
   localparam logic [REG_ADDR_W-1:0] pair_b [3] = '{5'd8, 5'd10, 5'd9};

   logic                  clk;
   logic                  rst_n;
   logic                  vld;
   logic [XLEN-1:0]       pc;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [REG_ADDR_W-1:0] rd;
   logic                  wen;
   logic [XLEN-1:0]       imm;
   logic                  alu_vld;
   logic [ALU_OP_W-1:0]   alu_op;
   logic                  alu_a_pc;
   logic                  alu_b_imm;
   logic                  bru_vld;
   logic [BRU_OP_W-1:0]   bru_op;
   logic [XLEN-1:0]       bru_offset;
   logic                  branch;
   logic [XLEN-1:0]       brn_addr;
   logic                  wb_vld;
   logic [REG_ADDR_W-1:0] wb_rd;
   logic [XLEN-1:0]       wb_data;

   // architectural model and expected commits / redirects
   logic [XLEN-1:0]       model_rf [NUM_REGS];
   logic [REG_ADDR_W-1:0] exp_rd [$];
   logic [XLEN-1:0]       exp_data [$];
   logic [XLEN-1:0]       exp_target [$];
   int                    exp_br_cyc [$];
   int                    cyc;
   int                    squash_left;
   logic [31:0]           rng_state;
   logic [REG_ADDR_W-1:0] mon_rd;
   logic [XLEN-1:0]       mon_data;
   logic [XLEN-1:0]       mon_target;

   exu_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .vld        (vld),
      .pc         (pc),
      .rs1        (rs1),
      .rs2        (rs2),
      .rd         (rd),
      .wen        (wen),
      .imm        (imm),
      .alu_vld    (alu_vld),
      .alu_op     (alu_op),
      .alu_a_pc   (alu_a_pc),
      .alu_b_imm  (alu_b_imm),
      .bru_vld    (bru_vld),
      .bru_op     (bru_op),
      .bru_offset (bru_offset),
      .branch     (branch),
      .brn_addr   (brn_addr),
      .wb_vld     (wb_vld),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_wb(input logic [REG_ADDR_W-1:0] want_rd, input logic [XLEN-1:0] want_data);
      if (wb_rd !== want_rd || wb_data !== want_data) begin
         stop_on_error($sformatf("mismatch at %0t: commit r%0d = %h, expected r%0d = %h",
            $time, wb_rd, wb_data, want_rd, want_data));
      end
   endtask

   task automatic check_redirect(input logic want_taken, input logic [XLEN-1:0] want_target);
      if (branch !== want_taken) begin
         stop_on_error($sformatf("mismatch at %0t: branch = %b, expected %b",
            $time, branch, want_taken));
      end else if (want_taken && brn_addr !== want_target) begin
         stop_on_error($sformatf("mismatch at %0t: brn_addr = %h, expected %h",
            $time, brn_addr, want_target));
      end
   endtask

   // xorshift32
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [XLEN-1:0] alu_ref(input logic [ALU_OP_W-1:0] op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
      logic [SHAMT_W-1:0] sh;
      logic [XLEN-1:0]    fill;
      sh = b[SHAMT_W-1:0];
      // sign bits shifted in from the top
      fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
      case (op)
         ALU_ADD:   return a + b;
         ALU_SUB:   return a + ~b + 1;
         ALU_AND:   return a & b;
         ALU_OR:    return a | b;
         ALU_XOR:   return a ^ b;
         ALU_SLL:   return a << sh;
         ALU_SRL:   return a >> sh;
         ALU_SRA:   return (a >> sh) | fill;
         ALU_SLT:   return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
         ALU_SLTU:  return XLEN'(a < b);
         ALU_PASSB: return b;
         default:   return '0;
      endcase
   endfunction

   function automatic logic bru_ref(input logic [BRU_OP_W-1:0] op,
                                    input logic [XLEN-1:0] x,
                                    input logic [XLEN-1:0] y);
      logic lt;
      lt = (x[XLEN-1] != y[XLEN-1]) ? x[XLEN-1] : (x < y);
      case (op)
         BRU_BEQ:  return x == y;
         BRU_BNE:  return x != y;
         BRU_BLT:  return lt;
         BRU_BGE:  return !lt;
         BRU_BLTU: return x < y;
         BRU_BGEU: return !(x < y);
         default:  return 1'b1;
      endcase
   endfunction

   // drives one D slot
   // model follows program order and skips the branch shadow
   task automatic send_instr(input logic is_bru, input logic [ALU_OP_W-1:0] aop,
         input logic [BRU_OP_W-1:0] bop, input logic a_pc, input logic b_imm,
         input logic [REG_ADDR_W-1:0] dst, input logic [REG_ADDR_W-1:0] src1,
         input logic [REG_ADDR_W-1:0] src2, input logic wr, input logic [XLEN-1:0] k,
         input logic [XLEN-1:0] at_pc);
      logic [XLEN-1:0] opa;
      logic [XLEN-1:0] opb;
      logic [XLEN-1:0] res;
      @(posedge clk);
      #1;
      vld        = 1'b1;
      pc         = at_pc;
      rs1        = src1;
      rs2        = src2;
      rd         = dst;
      wen        = wr;
      imm        = k;
      alu_vld    = ~is_bru;
      alu_op     = aop;
      alu_a_pc   = a_pc;
      alu_b_imm  = b_imm;
      bru_vld    = is_bru;
      bru_op     = bop;
      bru_offset = k;
      if (squash_left > 0) begin
         squash_left--;
      end else begin
         if (is_bru) begin
            res = at_pc + XLEN'(INSTR_BYTES);
            if (bru_ref(bop, model_rf[src1], model_rf[src2])) begin
               exp_target.push_back(bop == BRU_JIRL ? model_rf[src1] + k : at_pc + k);
               exp_br_cyc.push_back(cyc + 3);
               squash_left = 3;
            end
         end else begin
            opa = a_pc ? at_pc : model_rf[src1];
            opb = b_imm ? k : model_rf[src2];
            res = alu_ref(aop, opa, opb);
         end
         if (wr) begin
            exp_rd.push_back(dst);
            exp_data.push_back(res);
            if (dst != '0) begin
               model_rf[dst] = res;
            end
         end
      end
   endtask

   task automatic send_alu(input logic [ALU_OP_W-1:0] op, input logic [REG_ADDR_W-1:0] dst,
         input logic [REG_ADDR_W-1:0] src1, input logic [REG_ADDR_W-1:0] src2,
         input logic a_pc, input logic b_imm, input logic [XLEN-1:0] k,
         input logic [XLEN-1:0] at_pc);
      send_instr(1'b0, op, BRU_BEQ, a_pc, b_imm, dst, src1, src2, 1'b1, k, at_pc);
   endtask

   task automatic send_bru(input logic [BRU_OP_W-1:0] op, input logic [REG_ADDR_W-1:0] dst,
         input logic [REG_ADDR_W-1:0] src1, input logic [REG_ADDR_W-1:0] src2,
         input logic wr, input logic [XLEN-1:0] offs, input logic [XLEN-1:0] at_pc);
      send_instr(1'b1, ALU_ADD, op, 1'b0, 1'b0, dst, src1, src2, wr, offs, at_pc);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         vld = 1'b0;
         if (squash_left > 0) begin
            squash_left--;
         end
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_rd.size() != 0 || exp_br_cyc.size() != 0) begin
         if (waited == 20) begin
            stop_on_error("timeout: expected commits or redirects never appeared");
         end
         idle_cycles(1);
         waited++;
      end
      // a stray commit from a squashed slot would show up here
      idle_cycles(4);
   endtask

   // commit and redirect monitor sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (wb_vld) begin
            if (exp_rd.size() == 0) begin
               stop_on_error("a commit appeared where no instruction should commit");
            end else begin
               mon_rd   = exp_rd.pop_front();
               mon_data = exp_data.pop_front();
               check_wb(mon_rd, mon_data);
            end
         end
         if (exp_br_cyc.size() != 0 && exp_br_cyc[0] == cyc) begin
            exp_br_cyc.pop_front();
            mon_target = exp_target.pop_front();
            check_redirect(1'b1, mon_target);
         end else begin
            check_redirect(1'b0, '0);
         end
      end
   end

   task automatic alu_op_sweep();
      int i;
      for (i = 1; i <= 4; i++) begin
         send_alu(ALU_PASSB, REG_ADDR_W'(i), 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h100);
      end
      // negative value for sra and slt
      send_alu(ALU_PASSB, 5'd5, 5'd0, 5'd0, 1'b0, 1'b1, 32'h8000_0000 | next_rand(), 32'h100);
      for (i = 0; i < 3; i++) begin
         send_alu(ALU_XOR, 5'd20, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h100);
      end
      for (i = 0; i < 11; i++) begin
         send_alu(alu_ops[i], 5'd10, 5'd1, 5'd2, 1'b0, 1'b0, 32'h0, 32'h200);
         send_alu(alu_ops[i], 5'd11, 5'd5, 5'd0, 1'b0, 1'b1, next_rand(), 32'h204);
         send_alu(alu_ops[i], 5'd12, 5'd0, 5'd3, 1'b1, 1'b0, 32'h0, next_rand());
      end
      drain();
   endtask

   task automatic bypass_distances();
      int d;
      int f;
      for (d = 1; d <= 3; d++) begin
         send_alu(ALU_ADD, 5'd6, 5'd1, 5'd0, 1'b0, 1'b1, next_rand(), 32'h300);
         for (f = 1; f < d; f++) begin
            send_alu(ALU_XOR, 5'd20, 5'd2, 5'd3, 1'b0, 1'b0, 32'h0, 32'h304);
         end
         send_alu(ALU_ADD, 5'd7, 5'd6, 5'd6, 1'b0, 1'b0, 32'h0, 32'h308);
      end
      // M holds the younger write to r6
      send_alu(ALU_PASSB, 5'd6, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h310);
      send_alu(ALU_PASSB, 5'd6, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h314);
      send_alu(ALU_SUB, 5'd7, 5'd6, 5'd2, 1'b0, 1'b0, 32'h0, 32'h318);
      drain();
   endtask

   task automatic cond_branch_sweep();
      int op;
      int p;
      int s;
      send_alu(ALU_PASSB, 5'd7, 5'd0, 5'd0, 1'b0, 1'b1, 32'h0000_0005, 32'h400);
      send_alu(ALU_PASSB, 5'd8, 5'd0, 5'd0, 1'b0, 1'b1, 32'h0000_0005, 32'h404);
      send_alu(ALU_PASSB, 5'd9, 5'd0, 5'd0, 1'b0, 1'b1, 32'hffff_fffd, 32'h408);
      send_alu(ALU_PASSB, 5'd10, 5'd0, 5'd0, 1'b0, 1'b1, 32'h0000_0007, 32'h40c);
      for (op = 0; op < 6; op++) begin
         for (p = 0; p < 3; p++) begin
            send_bru(cond_ops[op], 5'd0, pair_a[p], pair_b[p], 1'b0,
               next_rand() & 32'h0000_fffc, 32'h2000);
            for (s = 0; s < 3; s++) begin
               send_alu(ALU_PASSB, 5'd11, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h2004);
            end
            send_alu(ALU_ADD, 5'd12, 5'd11, 5'd0, 1'b0, 1'b1, 32'h1, 32'h2010);
         end
      end
      drain();
   endtask

   task automatic jump_and_link();
      int s;
      send_bru(BRU_B, 5'd13, 5'd0, 5'd0, 1'b1, 32'h0000_0100, 32'h3000);
      for (s = 0; s < 3; s++) begin
         send_alu(ALU_PASSB, 5'd14, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h3004);
      end
      send_alu(ALU_ADD, 5'd15, 5'd13, 5'd0, 1'b0, 1'b1, 32'h4, 32'h3100);
      // jump base comes over the M bypass
      send_alu(ALU_PASSB, 5'd16, 5'd0, 5'd0, 1'b0, 1'b1, 32'h0000_8000, 32'h3104);
      send_bru(BRU_JIRL, 5'd17, 5'd16, 5'd0, 1'b1, 32'h0000_0024, 32'h3108);
      for (s = 0; s < 3; s++) begin
         send_alu(ALU_PASSB, 5'd14, 5'd0, 5'd0, 1'b0, 1'b1, next_rand(), 32'h310c);
      end
      send_alu(ALU_ADD, 5'd18, 5'd17, 5'd16, 1'b0, 1'b0, 32'h0, 32'h8024);
      drain();
   endtask

   task automatic zero_register();
      send_alu(ALU_PASSB, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 32'hdead_beef, 32'h500);
      send_alu(ALU_ADD, 5'd19, 5'd0, 5'd0, 1'b0, 1'b0, 32'h0, 32'h504);
      send_alu(ALU_OR, 5'd20, 5'd0, 5'd1, 1'b0, 1'b0, 32'h0, 32'h508);
      send_alu(ALU_ADD, 5'd21, 5'd0, 5'd0, 1'b0, 1'b1, 32'h0000_0005, 32'h50c);
      drain();
   endtask

   task automatic random_alu_stream();
      int n;
      int sel;
      logic [31:0]     r;
      logic [XLEN-1:0] k;
      logic [XLEN-1:0] p;
      for (n = 0; n < 200; n++) begin
         r   = next_rand();
         k   = next_rand();
         p   = next_rand() & 32'hffff_fffc;
         sel = int'(r[7:0]) % 11;
         send_alu(alu_ops[sel], r[12:8], r[17:13], r[22:18], r[23], r[24], k, p);
         if (r[27:25] == 3'd0) begin
            idle_cycles(1);
         end
      end
      drain();
   endtask

   initial begin
      int i;
      rng_state   = 32'h12e4_9d28;
      squash_left = 0;
      for (i = 0; i < NUM_REGS; i++) begin
         model_rf[i] = '0;
      end
      rst_n      = 1'b0;
      vld        = 1'b0;
      pc         = '0;
      rs1        = '0;
      rs2        = '0;
      rd         = '0;
      wen        = 1'b0;
      imm        = '0;
      alu_vld    = 1'b0;
      alu_op     = ALU_ADD;
      alu_a_pc   = 1'b0;
      alu_b_imm  = 1'b0;
      bru_vld    = 1'b0;
      bru_op     = BRU_BEQ;
      bru_offset = '0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      alu_op_sweep();
      bypass_distances();
      cond_branch_sweep();
      jump_and_link();
      zero_register();
      random_alu_stream();

      $display("** PASS **");
      $finish;
   end

endmodule
